// File: all.f
+incdir+include
src/calc_pkg.sv
src/key_release.sv
src/ascii_to_fixed.sv
src/fixed_to_ascii.sv
src/fixed_arith.sv
src/fixed_divider.sv
src/calc_ctrl.sv
src/calculator.sv
verif/calculator_tb.sv

// File: Bender.yml
package:
  name: calculator

export_include_dirs:
  - include

sources:
  - files:
      - src/calc_pkg.sv
      - src/key_release.sv
      - src/ascii_to_fixed.sv
      - src/fixed_to_ascii.sv
      - src/fixed_arith.sv
      - src/fixed_divider.sv
      - src/calc_ctrl.sv
      - src/calculator.sv
  - target: test
    files:
      - verif/calculator_tb.sv

// File: verif/calculator_tb.sv
`include "calc_defines.svh"

module calculator_tb;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_ROWS    = 6;

    logic                      clk;
    logic                      rst;
    logic [`CALC_NUM_KEYS-1:0] buttons;
    calc_pkg::text_t           display;
    calc_pkg::fixed_t          val1;
    calc_pkg::fixed_t          val2;
    logic                      done;

    int          errors;
    int          timeouts;
    logic [15:0] lfsr;

    // Stimulus table, one entry per row in each queue
    string            q_name[$];
    string            q_a[$];
    string            q_b[$];
    byte              q_op[$];
    calc_pkg::fixed_t q_v1[$];
    calc_pkg::fixed_t q_v2[$];
    string            q_res[$];

    calculator UUT (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .display (display),
        .val1    (val1),
        .val2    (val2),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic calc_pkg::text_t to_text(input string s);
        calc_pkg::text_t t;
        t = {`CALC_OUTLEN{8'h20}};
        for (int i = 0; i < s.len() && i < `CALC_OUTLEN; i++) begin
            t[8*(`CALC_OUTLEN-1-i) +: 8] = s[i];
        end
        return t;
    endfunction

    // Reference parser, digits past the limit are dropped
    function automatic calc_pkg::fixed_t parse_fixed(input string s);
        logic               neg;
        logic               in_frac;
        logic [`CALC_N-1:0] ip;
        logic [`CALC_N-1:0] fp;
        logic [`CALC_N-1:0] scale;
        logic [`CALC_N-1:0] mag;
        int                 ic;
        int                 fc;
        neg     = 1'b0;
        in_frac = 1'b0;
        ip      = '0;
        fp      = '0;
        scale   = 1;
        ic      = 0;
        fc      = 0;
        for (int i = 0; i < s.len(); i++) begin
            if (s[i] == "-") begin
                neg = 1'b1;
            end else if (s[i] == ".") begin
                in_frac = 1'b1;
            end else if (s[i] >= "0" && s[i] <= "9") begin
                if (!in_frac && ic < `CALC_MAX_DIGITS) begin
                    ip = ip * 10 + (s[i] - "0");
                    ic++;
                end else if (in_frac && fc < `CALC_MAX_DIGITS) begin
                    fp    = fp * 10 + (s[i] - "0");
                    scale = scale * 10;
                    fc++;
                end
            end
        end
        mag = (ip << `CALC_Q) + ((fp << `CALC_Q) / scale);
        return neg ? -mag : mag;
    endfunction

    // Reference formatter, five truncated fraction digits
    function automatic string format_fixed(input calc_pkg::fixed_t v);
        logic [`CALC_N-1:0] mag;
        logic [`CALC_N-1:0] ip;
        logic [`CALC_N-1:0] fp;
        string              s;
        mag = v[`CALC_N-1] ? -v : v;
        ip  = mag >> `CALC_Q;
        fp  = ((mag & ((64'd1 << `CALC_Q) - 1)) * 64'd100000) >> `CALC_Q;
        s   = $sformatf("%0d.%05d", ip, fp);
        if (v[`CALC_N-1]) begin
            s = {"-", s};
        end
        return s;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    function automatic int char_key(input byte c);
        if (c == ".") begin
            return int'(calc_pkg::KEY_POINT);
        end else if (c == "-") begin
            return int'(calc_pkg::KEY_MINUS);
        end
        return int'(c - "0");
    endfunction

    function automatic int op_key(input byte c);
        case (c)
            "+":     return int'(calc_pkg::KEY_PLUS);
            "-":     return int'(calc_pkg::KEY_MINUS);
            "*":     return int'(calc_pkg::KEY_MULT);
            default: return int'(calc_pkg::KEY_DIV);
        endcase
    endfunction

    task automatic add_row(input string name, input string a, input byte op, input string b,
                           input calc_pkg::fixed_t v1, input calc_pkg::fixed_t v2,
                           input string res);
        q_name.push_back(name);
        q_a.push_back(a);
        q_op.push_back(op);
        q_b.push_back(b);
        q_v1.push_back(v1);
        q_v2.push_back(v2);
        q_res.push_back(res);
    endtask

    task automatic check_value(input string name, input string what,
                               input calc_pkg::fixed_t exp, input calc_pkg::fixed_t act);
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0d actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_text(input string name, input string what,
                              input calc_pkg::text_t exp, input calc_pkg::text_t act);
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected \"%s\" actual \"%s\"", name, what, exp, act);
        end
    endtask

    task automatic do_reset();
        rst     = 1'b1;
        buttons = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
    endtask

    // High for one cycle, low for one cycle
    task automatic press(input int idx);
        buttons[idx] = 1'b1;
        @(negedge clk);
        buttons[idx] = 1'b0;
        @(negedge clk);
    endtask

    task automatic type_string(input string name, input string s);
        for (int i = 0; i < s.len(); i++) begin
            press(char_key(s[i]));
            @(negedge clk);
            check_text(name, "entry display", to_text(s.substr(0, i)), display);
        end
    endtask

    task automatic run_row(input int r);
        string name;
        int    cycles;
        logic  ok;
        name = q_name[r];
        do_reset();
        check_value(name, "done after reset", 0, done);
        check_text(name, "display after reset", to_text(""), display);
        check_value(name, "val1 after reset", 0, val1);
        check_value(name, "val2 after reset", 0, val2);

        type_string(name, q_a[r]);
        press(op_key(q_op[r]));
        @(negedge clk);
        check_text(name, "operator display", to_text($sformatf("%c", q_op[r])), display);
        type_string(name, q_b[r]);
        press(int'(calc_pkg::KEY_ENTER));
        check_value(name, "val1", q_v1[r], val1);
        check_value(name, "val2", q_v2[r], val2);

        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            ok = done;
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout in %s: done did not rise within %0d cycles", name,
                     TIMEOUT_CYCLES);
        end else begin
            check_text(name, "result display", to_text(q_res[r]), display);
            if (q_op[r] != "/") begin
                check_value(name, "done latency", 2, cycles);
            end
        end
    endtask

    initial begin
        int a;
        int b;
        int op_bit;
        rst      = 1'b1;
        buttons  = '0;
        errors   = 0;
        timeouts = 0;
        lfsr     = 16'd87;

        add_row("add_frac", "2.5", "+", "1.25", 64'sd351843720888320,
                64'sd175921860444160, "3.75000");
        add_row("sub_neg", "2.5", "-", "-1.25", 64'sd351843720888320,
                -64'sd175921860444160, "3.75000");
        add_row("mul_neg", "3", "*", "-0.5", 64'sd422212465065984,
                -64'sd70368744177664, "-1.50000");
        // 0.1 is truncated, so the sum falls just short of 1.1
        add_row("add_tenth", "0.1", "+", "1", 64'sd14073748835532,
                64'sd140737488355328, "1.09999");
        add_row("sub_to_neg", "1.25", "-", "2.5", 64'sd175921860444160,
                64'sd351843720888320, "-1.25000");
        add_row("div_half", "7", "/", "2", 64'sd985162418487296,
                64'sd281474976710656, "3.50000");
        add_row("div_quarter", "1", "/", "4", 64'sd140737488355328,
                64'sd562949953421312, "0.25000");
        add_row("div_neg", "-3", "/", "4", -64'sd422212465065984,
                64'sd562949953421312, "-0.75000");

        for (int i = 0; i < RANDOM_ROWS; i++) begin
            take_bits(10, a);
            take_bits(10, b);
            take_bits(1, op_bit);
            a = a % 1000;
            b = b % 1000;
            add_row($sformatf("rand_%0d", i), $sformatf("%0d", a), op_bit ? "-" : "+",
                    $sformatf("%0d", b), parse_fixed($sformatf("%0d", a)),
                    parse_fixed($sformatf("%0d", b)),
                    format_fixed(op_bit ? parse_fixed($sformatf("%0d", a))
                                          - parse_fixed($sformatf("%0d", b))
                                        : parse_fixed($sformatf("%0d", a))
                                          + parse_fixed($sformatf("%0d", b))));
        end

        for (int r = 0; r < q_name.size(); r++) begin
            run_row(r);
        end

        $display("Rows: %0d, errors: %0d, timeouts: %0d", q_name.size(), errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: src/calculator.sv
`include "calc_defines.svh"

module calculator (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CALC_NUM_KEYS-1:0] buttons,
    output calc_pkg::text_t           display,
    output calc_pkg::fixed_t          val1,
    output calc_pkg::fixed_t          val2,
    output logic                      done
);

    logic             key_valid;
    calc_pkg::key_t   key;
    calc_pkg::text_t  entry;
    calc_pkg::fixed_t entry_value;
    calc_pkg::fixed_t operand_a;
    calc_pkg::fixed_t operand_b;
    calc_pkg::fixed_t sum;
    calc_pkg::fixed_t diff;
    calc_pkg::fixed_t prod;
    calc_pkg::fixed_t quotient;
    logic             div_start;
    logic             div_done;
    calc_pkg::fixed_t result;
    calc_pkg::text_t  result_text;

    key_release u_keys (
        .clk       (clk),
        .rst       (rst),
        .buttons   (buttons),
        .key_valid (key_valid),
        .key       (key)
    );

    calc_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key         (key),
        .entry_value (entry_value),
        .sum         (sum),
        .diff        (diff),
        .prod        (prod),
        .quotient    (quotient),
        .div_done    (div_done),
        .result_text (result_text),
        .entry       (entry),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .result      (result),
        .div_start   (div_start),
        .display     (display),
        .val1        (val1),
        .val2        (val2),
        .done        (done)
    );

    ascii_to_fixed u_parse (
        .text  (entry),
        .value (entry_value)
    );

    fixed_arith u_arith (
        .a    (operand_a),
        .b    (operand_b),
        .sum  (sum),
        .diff (diff),
        .prod (prod)
    );

    fixed_divider u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (operand_a),
        .divisor  (operand_b),
        .quotient (quotient),
        .done     (div_done)
    );

    fixed_to_ascii u_format (
        .value (result),
        .text  (result_text)
    );

endmodule

// File: src/calc_ctrl.sv
`include "calc_defines.svh"

module calc_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             key_valid,
    input  calc_pkg::key_t   key,
    input  calc_pkg::fixed_t entry_value,
    input  calc_pkg::fixed_t sum,
    input  calc_pkg::fixed_t diff,
    input  calc_pkg::fixed_t prod,
    input  calc_pkg::fixed_t quotient,
    input  logic             div_done,
    input  calc_pkg::text_t  result_text,
    output calc_pkg::text_t  entry,
    output calc_pkg::fixed_t operand_a,
    output calc_pkg::fixed_t operand_b,
    output calc_pkg::fixed_t result,
    output logic             div_start,
    output calc_pkg::text_t  display,
    output calc_pkg::fixed_t val1,
    output calc_pkg::fixed_t val2,
    output logic             done
);

    typedef enum logic [2:0] {
        S_NUM1, S_OP, S_NUM2, S_CALC, S_WAIT_DIV, S_SHOW
    } state_t;

    localparam int IDX_W = $clog2(`CALC_OUTLEN + 1);
    localparam calc_pkg::text_t SPACES = {`CALC_OUTLEN{8'h20}};

    state_t           state;
    logic [IDX_W-1:0] wr_idx;
    calc_pkg::op_t    op;
    calc_pkg::char_t  key_char;
    calc_pkg::char_t  op_char;
    logic             is_sign;
    logic             is_char;
    logic             is_op;
    logic             can_append;
    logic             div_finished;

    // Minus on an empty entry is a sign, otherwise it is the operator
    assign is_sign    = key == calc_pkg::KEY_MINUS && wr_idx == '0;
    assign is_char    = key <= calc_pkg::KEY_9 || key == calc_pkg::KEY_POINT || is_sign;
    assign is_op      = key >= calc_pkg::KEY_PLUS && key <= calc_pkg::KEY_DIV;
    assign can_append = wr_idx < IDX_W'(`CALC_OUTLEN);

    // Divider done is stale while our start pulse is still out
    assign div_finished = state == S_WAIT_DIV && !div_start && div_done;

    assign operand_a = val1;
    assign operand_b = val2;

    always_comb begin
        if (key == calc_pkg::KEY_POINT) begin
            key_char = ".";
        end else if (key == calc_pkg::KEY_MINUS) begin
            key_char = "-";
        end else begin
            key_char = 8'("0" + key);
        end
    end

    always_comb begin
        case (op)
            calc_pkg::OP_ADD: op_char = "+";
            calc_pkg::OP_SUB: op_char = "-";
            calc_pkg::OP_MUL: op_char = "*";
            default:          op_char = "/";
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_NUM1;
            wr_idx    <= '0;
            op        <= calc_pkg::OP_ADD;
            entry     <= SPACES;
            display   <= SPACES;
            val1      <= '0;
            val2      <= '0;
            div_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                S_NUM1, S_NUM2: begin
                    display <= entry;
                    if (key_valid && is_char && can_append) begin
                        entry[8*(`CALC_OUTLEN-1-wr_idx) +: 8] <= key_char;
                        wr_idx <= wr_idx + 1'b1;
                    end else if (key_valid && is_op && state == S_NUM1) begin
                        // Operator keys follow KEY_PLUS in op_t order
                        op    <= calc_pkg::op_t'(key[1:0]);
                        val1  <= entry_value;
                        state <= S_OP;
                    end else if (key_valid && key == calc_pkg::KEY_ENTER && state == S_NUM2) begin
                        val2  <= entry_value;
                        state <= S_CALC;
                    end
                end
                S_OP: begin
                    entry   <= SPACES;
                    wr_idx  <= '0;
                    display <= {op_char, SPACES[8*`CALC_OUTLEN-9:0]};
                    state   <= S_NUM2;
                end
                S_CALC: begin
                    if (op == calc_pkg::OP_DIV) begin
                        div_start <= 1'b1;
                        state     <= S_WAIT_DIV;
                    end else begin
                        state <= S_SHOW;
                    end
                end
                S_WAIT_DIV: begin
                    div_start <= 1'b0;
                    if (div_finished) begin
                        state <= S_SHOW;
                    end
                end
                S_SHOW: begin
                    display <= result_text;
                    done    <= 1'b1;
                end
                default: state <= S_NUM1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_CALC) begin
            case (op)
                calc_pkg::OP_ADD: result <= sum;
                calc_pkg::OP_SUB: result <= diff;
                calc_pkg::OP_MUL: result <= prod;
                default: ;
            endcase
        end else if (div_finished) begin
            result <= quotient;
        end
    end

    // Once done, the shown result stays put
    done_sticky: assert property (@(posedge clk) disable iff (rst)
        done |=> done && $stable(display));

endmodule

// File: src/fixed_divider.sv
`include "calc_defines.svh"

module fixed_divider (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  calc_pkg::fixed_t dividend,
    input  calc_pkg::fixed_t divisor,
    output calc_pkg::fixed_t quotient,
    output logic             done
);

    localparam int STEPS = `CALC_N + `CALC_Q;
    localparam int CW    = $clog2(STEPS);

    logic [CW-1:0]       count;
    logic [STEPS-1:0]    dvd;
    logic [`CALC_N-1:0]  dvs;
    logic [`CALC_N-1:0]  rem;
    logic [`CALC_N-1:0]  quo;
    logic                neg;
    logic [`CALC_N-1:0]  mag_a;
    logic [`CALC_N-1:0]  mag_b;
    logic [`CALC_N:0]    trial;
    logic                fits;
    logic [`CALC_N-1:0]  rem_next;
    logic [`CALC_N-1:0]  quo_next;

    assign mag_a = dividend[`CALC_N-1] ? -dividend : dividend;
    assign mag_b = divisor[`CALC_N-1] ? -divisor : divisor;

    // One restoring step, next dividend bit into the remainder
    assign trial    = {rem, dvd[STEPS-1]};
    assign fits     = trial >= {1'b0, dvs};
    assign rem_next = fits ? `CALC_N'(trial - {1'b0, dvs}) : trial[`CALC_N-1:0];
    assign quo_next = {quo[`CALC_N-2:0], fits};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done  <= 1'b1;
            count <= '0;
        end else if (done && start) begin
            done  <= 1'b0;
            count <= CW'(STEPS - 1);
        end else if (!done) begin
            count <= count - 1'b1;
            if (count == '0) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done && start) begin
            // Pre-scale by 2^Q so the quotient comes out in Q16.47
            dvd <= {mag_a, {`CALC_Q{1'b0}}};
            dvs <= mag_b;
            rem <= '0;
            quo <= '0;
            neg <= dividend[`CALC_N-1] ^ divisor[`CALC_N-1];
        end else if (!done) begin
            dvd <= dvd << 1;
            rem <= rem_next;
            quo <= quo_next;
            if (count == '0) begin
                quotient <= neg ? -quo_next : quo_next;
            end
        end
    end

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> done);

    busy_length: assert property (@(posedge clk) disable iff (rst)
        start |=> !done [*STEPS] ##1 done);

endmodule

// File: src/fixed_arith.sv
`include "calc_defines.svh"

module fixed_arith (
    input  calc_pkg::fixed_t a,
    input  calc_pkg::fixed_t b,
    output calc_pkg::fixed_t sum,
    output calc_pkg::fixed_t diff,
    output calc_pkg::fixed_t prod
);

    logic [`CALC_N-1:0]   mag_a;
    logic [`CALC_N-1:0]   mag_b;
    logic [2*`CALC_N-1:0] full;
    logic [`CALC_N-1:0]   mag_p;

    // Plain wrap-around
    assign sum  = a + b;
    assign diff = a - b;

    assign mag_a = a[`CALC_N-1] ? -a : a;
    assign mag_b = b[`CALC_N-1] ? -b : b;

    assign full = mag_a * mag_b;

    // Drop the extra fraction bits and anything above the sign position
    assign mag_p = {1'b0, full[`CALC_Q +: `CALC_N-1]};

    assign prod = (a[`CALC_N-1] ^ b[`CALC_N-1]) ? -mag_p : mag_p;

endmodule

// File: src/fixed_to_ascii.sv
`include "calc_defines.svh"

module fixed_to_ascii (
    input  calc_pkg::fixed_t value,
    output calc_pkg::text_t  text
);

    localparam int INT_W = `CALC_N - 1 - `CALC_Q;

    logic                 neg;
    logic [`CALC_N-1:0]   mag;
    logic [INT_W-1:0]     int_rem;
    logic [`CALC_N-1:0]   frac_scaled;
    logic [16:0]          frac_rem;
    logic [3:0]           int_dig [`CALC_MAX_DIGITS];
    logic                 lead;
    int                   pos;

    always_comb begin
        neg = value[`CALC_N-1];
        mag = neg ? -value : value;

        text = {`CALC_OUTLEN{8'h20}};
        pos  = 0;
        if (neg) begin
            text[8*(`CALC_OUTLEN-1-pos) +: 8] = "-";
            pos = pos + 1;
        end

        // Split the integer part into decimal digits
        int_rem = mag[`CALC_N-2:`CALC_Q];
        for (int k = 0; k < `CALC_MAX_DIGITS; k++) begin
            int_dig[k] = 4'(int_rem % 10);
            int_rem    = int_rem / 10;
        end

        // Suppress leading zeros but always keep the ones digit
        lead = 1'b0;
        for (int k = `CALC_MAX_DIGITS - 1; k >= 0; k--) begin
            if (int_dig[k] != 4'd0 || lead || k == 0) begin
                text[8*(`CALC_OUTLEN-1-pos) +: 8] = "0" + int_dig[k];
                pos  = pos + 1;
                lead = 1'b1;
            end
        end

        text[8*(`CALC_OUTLEN-1-pos) +: 8] = ".";
        pos = pos + 1;

        // Five truncated fraction digits
        frac_scaled = (`CALC_N'(mag[`CALC_Q-1:0]) * 64'd100000) >> `CALC_Q;
        frac_rem    = frac_scaled[16:0];
        for (int m = 4; m >= 0; m--) begin
            text[8*(`CALC_OUTLEN-1-(pos+m)) +: 8] = "0" + 8'(frac_rem % 10);
            frac_rem = frac_rem / 10;
        end
    end

endmodule

// File: src/ascii_to_fixed.sv
`include "calc_defines.svh"

module ascii_to_fixed (
    input  calc_pkg::text_t  text,
    output calc_pkg::fixed_t value
);

    calc_pkg::char_t     c;
    logic                neg;
    logic                in_frac;
    logic                seen_num;
    logic [16:0]         int_acc;
    logic [16:0]         frac_acc;
    logic [3:0]          int_cnt;
    logic [3:0]          frac_cnt;
    logic [16:0]         scale;
    logic [`CALC_N-1:0]  mag;

    always_comb begin
        neg      = 1'b0;
        in_frac  = 1'b0;
        seen_num = 1'b0;
        int_acc  = '0;
        frac_acc = '0;
        int_cnt  = '0;
        frac_cnt = '0;

        // Left to right, spaces and stray characters fall through
        for (int i = 0; i < `CALC_OUTLEN; i++) begin
            c = text[8*(`CALC_OUTLEN-1-i) +: 8];
            if (c == "-" && !seen_num) begin
                neg      = 1'b1;
                seen_num = 1'b1;
            end else if (c == ".") begin
                in_frac  = 1'b1;
                seen_num = 1'b1;
            end else if (c >= "0" && c <= "9") begin
                seen_num = 1'b1;
                if (!in_frac && int_cnt < `CALC_MAX_DIGITS) begin
                    int_acc = int_acc * 10 + (c - "0");
                    int_cnt = int_cnt + 1'b1;
                end else if (in_frac && frac_cnt < `CALC_MAX_DIGITS) begin
                    frac_acc = frac_acc * 10 + (c - "0");
                    frac_cnt = frac_cnt + 1'b1;
                end
            end
        end

        // Ten to the number of fraction digits
        scale = 17'd1;
        for (int j = 0; j < `CALC_MAX_DIGITS; j++) begin
            if (j < frac_cnt) begin
                scale = scale * 10;
            end
        end

        mag = (`CALC_N'(int_acc) << `CALC_Q)
            + ((`CALC_N'(frac_acc) << `CALC_Q) / `CALC_N'(scale));

        value = neg ? -mag : mag;
    end

endmodule

// File: src/key_release.sv
`include "calc_defines.svh"

module key_release (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CALC_NUM_KEYS-1:0] buttons,
    output logic                      key_valid,
    output calc_pkg::key_t            key
);

    logic [`CALC_NUM_KEYS-1:0] prev;
    logic [`CALC_NUM_KEYS-1:0] released;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev <= '0;
        end else begin
            prev <= buttons;
        end
    end

    // Falling level on any button
    assign released  = prev & ~buttons;
    assign key_valid = |released;

    // Lowest index wins when several drop together
    always_comb begin
        key = calc_pkg::KEY_0;
        for (int i = `CALC_NUM_KEYS - 1; i >= 0; i--) begin
            if (released[i]) begin
                key = calc_pkg::key_t'(i);
            end
        end
    end

    // Reported key was released and nothing below it was
    lowest_release_wins: assert property (@(posedge clk) disable iff (rst)
        key_valid |-> released[key]
            && (released & ((`CALC_NUM_KEYS'(1) << key) - 1'b1)) == '0);

endmodule

// File: src/calc_pkg.sv
`include "calc_defines.svh"

package calc_pkg;

    typedef logic signed [`CALC_N-1:0] fixed_t;

    typedef logic [7:0] char_t;

    // Leftmost character sits in the top byte
    typedef logic [8*`CALC_OUTLEN-1:0] text_t;

    // Value doubles as the button bit index
    typedef enum logic [4:0] {
        KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
        KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
        KEY_POINT,
        KEY_ENTER,
        KEY_PLUS,
        KEY_MINUS,
        KEY_MULT,
        KEY_DIV
    } key_t;

    typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL, OP_DIV} op_t;

endpackage

// File: include/calc_defines.svh
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// Q16.47 word
`define CALC_N 64
`define CALC_Q 47

// Display and entry width in characters
`define CALC_OUTLEN 16

// Digits accepted on each side of the point
`define CALC_MAX_DIGITS 5

// Digits, point, enter and four operators, plus one spare line
`define CALC_NUM_KEYS 17

`endif
